// File: Bender.yml
package:
  name: wisc_decode

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/wiscPkg.sv
      - verilog/control.sv
      - verilog/regFileBypass.sv
      - verilog/operandSelect.sv
      - verilog/decode.sv
  - target: test
    files:
      - dv/decodeTb.sv

// File: build.f
+incdir+verilog
verilog/wiscPkg.sv
verilog/control.sv
verilog/regFileBypass.sv
verilog/operandSelect.sv
verilog/decode.sv
dv/decodeTb.sv

// File: dv/decodeTb.sv
/*
   Self-checking testbench for the decode stage, replays dv/decode_golden.txt one vector
   per clock; run from the project root
*/
`timescale 1ns/100ps
`default_nettype none

module decodeTb;

   localparam int CLK_PERIOD = 8;
   localparam int NUM_FIELDS = 27;

   logic clk;
   logic rst;
   logic stall;
   logic valid;
   logic flush;
   logic flushAgain;
   logic flushFinal;
   logic alignErr;
   logic mwAlignErr;
   logic mwRegWrite;
   wiscPkg::regIdxT mwWriteReg;
   wiscPkg::wordT writeData;
   wiscPkg::wordT instr;

   wire wiscPkg::regSrcT regSrc;
   wire wiscPkg::regDestT regDest;
   wire wiscPkg::brControlT brControl;
   wire wiscPkg::setControlT setControl;
   wire wiscPkg::aluOpT aluOp;
   wire regWrite;
   wire memWrite;
   wire memRead;
   wire memAccess;
   wire aluJump;
   wire jump;
   wire immSrc;
   wire invA;
   wire invB;
   wire cin;
   wire stu;
   wire btr;
   wire lbi;
   wire setIf;
   wire halt;
   wire wiscPkg::wordT aluA;
   wire wiscPkg::wordT aluB;
   wire wiscPkg::wordT read2Data;
   wire wiscPkg::wordT imm8Ext;
   wire wiscPkg::wordT imm11Ext;
   wire wiscPkg::regIdxT writeReg;

   // expected values of the current vector
   wiscPkg::wordT expAluA;
   wiscPkg::wordT expAluB;
   wiscPkg::wordT expRead2;
   wiscPkg::wordT expImm8;
   wiscPkg::wordT expImm11;
   wiscPkg::regIdxT expWriteReg;
   logic [2:0] expAluOp;
   logic [1:0] expRegSrc;
   logic [2:0] expBr;
   logic [1:0] expSet;
   logic expRegWrite;
   logic expMemWrite;
   logic expMemRead;
   logic expMemAccess;
   logic expJump;
   logic expHalt;

   // control bits the golden file leaves out, predicted from the instruction set
   wiscPkg::regDestT expRegDest;
   logic expAluJump;
   logic expImmSrc;
   logic expInvA;
   logic expInvB;
   logic expCin;
   logic expStu;
   logic expBtr;
   logic expLbi;
   logic expSetIf;

   string vectors [$];
   int errors;
   int vecNum;
   bit started;

   decode UUT (
      .clk(clk), .rst(rst), .stall(stall), .instr(instr), .valid(valid),
      .writeData(writeData), .mwRegWrite(mwRegWrite), .mwWriteReg(mwWriteReg),
      .alignErr(alignErr), .flush(flush), .flushAgain(flushAgain),
      .flushFinal(flushFinal), .mwAlignErr(mwAlignErr),
      .regSrc(regSrc), .regDest(regDest), .regWrite(regWrite), .memWrite(memWrite),
      .memRead(memRead), .memAccess(memAccess), .aluJump(aluJump), .jump(jump),
      .immSrc(immSrc), .brControl(brControl), .setControl(setControl), .aluOp(aluOp),
      .invA(invA), .invB(invB), .cin(cin), .stu(stu), .btr(btr), .lbi(lbi),
      .setIf(setIf), .halt(halt),
      .aluA(aluA), .aluB(aluB), .read2Data(read2Data), .imm8Ext(imm8Ext),
      .imm11Ext(imm11Ext), .writeReg(writeReg)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic compareWord(input string name, input wiscPkg::wordT got,
      input wiscPkg::wordT want);
      if (got !== want) begin
         errors++;
         $display("FAILED at %0t: vector %0d %s = %h, expected %h", $time, vecNum, name,
            got, want);
      end
   endtask

   task automatic compareIdx(input string name, input wiscPkg::regIdxT got,
      input wiscPkg::regIdxT want);
      if (got !== want) begin
         errors++;
         $display("FAILED at %0t: vector %0d %s = %0d, expected %0d", $time, vecNum, name,
            got, want);
      end
   endtask

   task automatic compareAluOp(input wiscPkg::aluOpT got, input wiscPkg::aluOpT want);
      if (got !== want) begin
         errors++;
         $display("FAILED at %0t: vector %0d aluOp = %h, expected %h", $time, vecNum,
            got, want);
      end
   endtask

   task automatic compareRegSrc(input wiscPkg::regSrcT got, input wiscPkg::regSrcT want);
      if (got !== want) begin
         errors++;
         $display("FAILED at %0t: vector %0d regSrc = %h, expected %h", $time, vecNum,
            got, want);
      end
   endtask

   task automatic compareRegDest(input wiscPkg::regDestT got,
      input wiscPkg::regDestT want);
      if (got !== want) begin
         errors++;
         $display("FAILED at %0t: vector %0d regDest = %h, expected %h", $time, vecNum,
            got, want);
      end
   endtask

   task automatic compareBranch(input wiscPkg::brControlT got,
      input wiscPkg::brControlT want);
      if (got !== want) begin
         errors++;
         $display("FAILED at %0t: vector %0d brControl = %h, expected %h", $time, vecNum,
            got, want);
      end
   endtask

   task automatic compareSet(input wiscPkg::setControlT got,
      input wiscPkg::setControlT want);
      if (got !== want) begin
         errors++;
         $display("FAILED at %0t: vector %0d setControl = %h, expected %h", $time, vecNum,
            got, want);
      end
   endtask

   task automatic compareBit(input string name, input logic got, input logic want);
      if (got !== want) begin
         errors++;
         $display("FAILED at %0t: vector %0d %s = %b, expected %b", $time, vecNum, name,
            got, want);
      end
   endtask

   task automatic loadVectors(output bit ok);
      int fd;
      string line;
      ok = 1'b0;
      fd = $fopen("dv/decode_golden.txt", "r");
      if (fd == 0) begin
         $display("could not open the golden file dv/decode_golden.txt");
      end else begin
         while ($fgets(line, fd) != 0) begin
            // skip comment and blank lines
            if (line.len() > 1 && line.getc(0) != "#") begin
               vectors.push_back(line);
            end
         end
         $fclose(fd);
         if (vectors.size() == 0) begin
            $display("the golden file ended before any vector was found");
         end else begin
            ok = 1'b1;
         end
      end
   endtask

   // scanning drives the DUT inputs directly
   task automatic applyVector(input string line, output bit ok);
      int n;
      n = $sscanf(line,
            "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
            stall, valid, flush, flushAgain, flushFinal, alignErr, mwAlignErr, mwRegWrite,
            mwWriteReg, writeData, instr, expAluA, expAluB, expRead2, expImm8, expImm11,
            expWriteReg, expAluOp, expRegSrc, expBr, expSet, expRegWrite, expMemWrite,
            expMemRead, expMemAccess, expJump, expHalt);
      ok = (n == NUM_FIELDS);
   endtask

   // instruction set table for the applied slot, a flush gives nop and a fault gives halt
   task automatic predictControl();
      logic [4:0] op;
      logic [1:0] fn;
      op = instr[15:11];
      fn = instr[1:0];
      if (alignErr) begin
         op = 5'b00000;
      end
      if (flush | flushAgain | flushFinal) begin
         op = 5'b00001;
         fn = 2'b00;
      end
      expRegDest = wiscPkg::DEST_RD_HI;
      expAluJump = 1'b0;
      expImmSrc = 1'b0;
      expInvA = 1'b0;
      expInvB = 1'b0;
      expStu = 1'b0;
      expBtr = 1'b0;
      expLbi = 1'b0;
      expSetIf = 1'b0;
      case (op)
         5'b00100, 5'b00110: begin
            expRegDest = wiscPkg::DEST_LINK;
            expImmSrc = 1'b1;
         end
         5'b00101, 5'b00111: begin
            expRegDest = wiscPkg::DEST_LINK;
            expAluJump = 1'b1;
         end
         // subi computes imm - rs
         5'b01001: expInvA = 1'b1;
         5'b10000, 5'b10010: expRegDest = wiscPkg::DEST_RS;
         5'b10011: begin
            expRegDest = wiscPkg::DEST_RS;
            expStu = 1'b1;
         end
         5'b11000: begin
            expRegDest = wiscPkg::DEST_RS;
            expLbi = 1'b1;
         end
         5'b11001: begin
            expRegDest = wiscPkg::DEST_RD_LO;
            expBtr = 1'b1;
         end
         5'b11010: expRegDest = wiscPkg::DEST_RD_LO;
         5'b11011: begin
            expRegDest = wiscPkg::DEST_RD_LO;
            expInvA = (fn == 2'b01);
         end
         // seq, slt and sle compare by rs - rt, sco only adds
         5'b11100, 5'b11101, 5'b11110: begin
            expRegDest = wiscPkg::DEST_RD_LO;
            expSetIf = 1'b1;
            expInvB = 1'b1;
         end
         5'b11111: begin
            expRegDest = wiscPkg::DEST_RD_LO;
            expSetIf = 1'b1;
         end
         default: ;
      endcase
      // two's complement subtraction needs the carry in
      expCin = expInvA | expInvB;
      expAluJump = expAluJump & valid;
   endtask

   task automatic checkOutputs();
      compareWord("aluA", aluA, expAluA);
      compareWord("aluB", aluB, expAluB);
      compareWord("read2Data", read2Data, expRead2);
      compareWord("imm8Ext", imm8Ext, expImm8);
      compareWord("imm11Ext", imm11Ext, expImm11);
      compareIdx("writeReg", writeReg, expWriteReg);
      compareAluOp(aluOp, wiscPkg::aluOpT'(expAluOp));
      compareRegSrc(regSrc, wiscPkg::regSrcT'(expRegSrc));
      compareRegDest(regDest, expRegDest);
      compareBranch(brControl, wiscPkg::brControlT'(expBr));
      compareSet(setControl, wiscPkg::setControlT'(expSet));
      compareBit("regWrite", regWrite, expRegWrite);
      compareBit("memWrite", memWrite, expMemWrite);
      compareBit("memRead", memRead, expMemRead);
      compareBit("memAccess", memAccess, expMemAccess);
      compareBit("jump", jump, expJump);
      compareBit("halt", halt, expHalt);
      compareBit("aluJump", aluJump, expAluJump);
      compareBit("immSrc", immSrc, expImmSrc);
      compareBit("invA", invA, expInvA);
      compareBit("invB", invB, expInvB);
      compareBit("cin", cin, expCin);
      compareBit("stu", stu, expStu);
      compareBit("btr", btr, expBtr);
      compareBit("lbi", lbi, expLbi);
      compareBit("setIf", setIf, expSetIf);
   endtask

   initial begin
      wait (started);
      #((vectors.size() + 10) * CLK_PERIOD);
      $display("watchdog expired, the vector loop did not finish in time");
      $display("tests failed");
      $finish;
   end

   initial begin
      bit loaded;
      bit lineOk;
      rst = 1'b1;
      stall = 1'b0;
      valid = 1'b0;
      flush = 1'b0;
      flushAgain = 1'b0;
      flushFinal = 1'b0;
      alignErr = 1'b0;
      mwAlignErr = 1'b0;
      mwRegWrite = 1'b0;
      mwWriteReg = '0;
      writeData = '0;
      instr = '0;
      errors = 0;
      vecNum = 0;
      started = 1'b0;
      loadVectors(loaded);
      if (!loaded) begin
         $display("tests failed");
         $finish;
      end else begin
         started = 1'b1;
         repeat (2) @(posedge clk);
         foreach (vectors[i]) begin
            #1;
            rst = 1'b0;
            vecNum = i + 1;
            applyVector(vectors[i], lineOk);
            // sample just before the next rising edge
            #(CLK_PERIOD - 2);
            if (lineOk) begin
               predictControl();
               checkOutputs();
            end else begin
               errors++;
               $display("golden vector %0d does not hold %0d fields", vecNum, NUM_FIELDS);
            end
            @(posedge clk);
         end
         $display("decode: %0d vectors run, %0d errors", vectors.size(), errors);
         if (errors == 0) begin
            $display("all tests passed");
         end else begin
            $display("tests failed");
         end
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: dv/decode_golden.txt
# inputs: stall valid flush flushAgain flushFinal alignErr mwAlignErr mwRegWrite
#   mwWriteReg writeData instr, then expected aluA aluB read2Data imm8Ext imm11Ext
#   writeReg aluOp regSrc brControl setControl regWrite memWrite memRead memAccess jump halt
0 1 0 0 0 0 0 1 1 1234 0800  0000 0000 0000 0000 0000 0 4 0 0 0 0 0 0 0 0 0
0 1 0 0 0 0 0 1 2 abcd d94c  1234 abcd abcd 004c 014c 3 4 0 0 0 1 0 0 0 0 0
1 1 0 0 0 0 0 1 3 5555 d96c  1234 0000 0000 006c 016c 3 4 0 0 0 1 0 0 0 0 0
0 1 0 0 0 0 1 1 4 6666 db94  0000 0000 0000 ff94 0394 5 4 0 0 0 1 0 0 0 0 0
0 1 0 0 0 0 0 1 7 8001 db94  0000 0000 0000 ff94 0394 5 4 0 0 0 1 0 0 0 0 0
0 1 0 0 0 0 0 0 0 0000 d95a  1234 abcd abcd 005a 015a 6 6 0 0 0 1 0 0 0 0 0
0 1 0 0 0 0 0 0 0 0000 d72b  8001 1234 1234 002b ff2b 2 3 0 0 0 1 0 0 0 0 0
0 1 0 0 0 0 0 0 0 0000 4153  1234 fff3 abcd 0053 0153 2 4 0 0 0 1 0 0 0 0 0
0 1 0 0 0 0 0 0 0 0000 5153  1234 0013 abcd 0053 0153 2 6 0 0 0 1 0 0 0 0 0
0 1 0 0 0 0 0 0 0 0000 929c  abcd 009c 0000 009c 029c 2 5 0 0 0 1 0 0 0 0 0
0 1 0 0 0 0 0 0 0 0000 8964  1234 0004 0000 0064 0164 3 4 1 0 0 1 0 1 1 0 0
0 1 0 0 0 0 0 0 0 0000 873f  8001 ffff 1234 003f ff3f 7 4 0 0 0 0 1 0 1 0 0
0 1 0 0 0 0 0 0 0 0000 9a22  abcd 0002 1234 0022 0222 2 4 0 0 0 1 1 0 1 0 0
0 1 0 0 0 0 0 0 0 0000 61f0  1234 0000 8001 fff0 01f0 7 4 0 4 0 0 0 0 0 0 0
0 1 0 0 0 0 0 0 0 0000 7210  abcd 0000 0000 0010 0210 0 4 0 6 0 0 0 0 0 0 0
0 1 0 0 0 0 0 0 0 0000 3401  0000 0000 0000 0001 fc01 7 4 2 0 0 1 0 0 0 1 0
0 1 0 0 0 0 0 0 0 0000 3908  1234 0008 0000 0008 0108 7 4 2 0 0 1 0 0 0 1 0
0 1 0 0 0 0 0 0 0 0000 e950  1234 abcd abcd 0050 0150 4 4 0 0 1 1 0 0 0 0 0
0 1 0 0 0 0 0 0 0 0000 ffe4  8001 8001 8001 ffe4 ffe4 1 4 0 0 3 1 0 0 0 0 0
0 1 1 0 0 0 0 0 0 0000 8964  0000 0000 0000 0000 0000 0 4 0 0 0 0 0 0 0 0 0
0 1 0 1 0 0 0 0 0 0000 3401  0000 0000 0000 0000 0000 0 4 0 0 0 0 0 0 0 0 0
0 1 0 0 1 0 0 0 0 0000 873f  0000 0000 0000 0000 0000 0 4 0 0 0 0 0 0 0 0 0
0 1 0 0 0 1 0 0 0 0000 d94c  1234 abcd abcd 004c 014c 2 4 0 0 0 0 0 0 0 0 1
0 0 0 0 0 0 0 0 0 0000 8964  1234 0004 0000 0064 0164 3 4 1 0 0 0 0 0 0 0 0
0 0 0 0 0 1 0 0 0 0000 d94c  1234 abcd abcd 004c 014c 2 4 0 0 0 0 0 0 0 0 0
0 1 0 0 0 0 0 0 0 0000 bab1  abcd 0011 0000 00b1 02b1 5 3 0 0 0 1 0 0 0 0 0
0 1 0 0 0 0 0 1 5 7e7e bdb1  7e7e 0011 7e7e 00b1 fdb1 5 3 0 0 0 1 0 0 0 0 0
0 1 0 0 0 0 0 0 0 0000 bdb1  7e7e 0011 7e7e 00b1 fdb1 5 3 0 0 0 1 0 0 0 0 0

// File: verilog/control.sv
/*
   Main decoder: turns opcode and function bits into execute, memory and writeback control
*/
`timescale 1ns/100ps
`default_nettype none

module control (
   input wire wiscPkg::opcodeT opcode,
   input wire [1:0] funct,
   input wire valid,
   output wiscPkg::aluSrcT aluSrc,
   output logic zeroExt,
   output wiscPkg::regSrcT regSrc,
   output wiscPkg::regDestT regDest,
   output logic regWrite,
   output logic memWrite,
   output logic memRead,
   output logic memAccess,
   output logic aluJump,
   output logic jump,
   output logic immSrc,
   output wiscPkg::brControlT brControl,
   output wiscPkg::setControlT setControl,
   output wiscPkg::aluOpT aluOp,
   output logic invA,
   output logic invB,
   output logic cin,
   output logic stu,
   output logic btr,
   output logic lbi,
   output logic setIf,
   output logic halt
);

   always_comb begin
      // defaults describe a nop
      aluSrc = wiscPkg::SRC_REG;
      zeroExt = 1'b0;
      regSrc = wiscPkg::WB_ALU;
      regDest = wiscPkg::DEST_RD_HI;
      regWrite = 1'b0;
      memWrite = 1'b0;
      memRead = 1'b0;
      aluJump = 1'b0;
      jump = 1'b0;
      immSrc = 1'b0;
      brControl = wiscPkg::BR_NONE;
      setControl = wiscPkg::SET_EQ;
      aluOp = wiscPkg::ALU_ADD;
      invA = 1'b0;
      invB = 1'b0;
      cin = 1'b0;
      stu = 1'b0;
      btr = 1'b0;
      lbi = 1'b0;
      setIf = 1'b0;
      halt = 1'b0;

      case (opcode)
         5'b00000: halt = 1'b1;
         // j and jal take the 11-bit displacement
         5'b00100, 5'b00110: begin
            jump = 1'b1;
            immSrc = 1'b1;
            regWrite = opcode[1];
            regDest = wiscPkg::DEST_LINK;
            regSrc = wiscPkg::WB_PC2;
         end
         // jr and jalr, target is rs + imm8 out of the alu
         5'b00101, 5'b00111: begin
            jump = 1'b1;
            aluJump = 1'b1;
            aluSrc = wiscPkg::SRC_IMM8;
            regWrite = opcode[1];
            regDest = wiscPkg::DEST_LINK;
            regSrc = wiscPkg::WB_PC2;
         end
         // addi, subi, xori, andni
         5'b01000, 5'b01001, 5'b01010, 5'b01011: begin
            aluSrc = wiscPkg::SRC_IMM5;
            regWrite = 1'b1;
            zeroExt = opcode[1];
            invA = (opcode[1:0] == 2'b01);
            cin = (opcode[1:0] == 2'b01);
            case (opcode[1:0])
               2'b10: aluOp = wiscPkg::ALU_XOR;
               2'b11: aluOp = wiscPkg::ALU_ANDN;
               default: aluOp = wiscPkg::ALU_ADD;
            endcase
         end
         // conditional branches pass rs through the alu to test it
         5'b01100, 5'b01101, 5'b01110, 5'b01111: begin
            aluSrc = wiscPkg::SRC_ZERO;
            brControl = wiscPkg::brControlT'({1'b1, opcode[1:0]});
         end
         // st and stu share the address path, stu also writes rs back
         5'b10000, 5'b10011: begin
            aluSrc = wiscPkg::SRC_IMM5;
            memWrite = 1'b1;
            stu = opcode[0];
            regWrite = opcode[0];
            regDest = wiscPkg::DEST_RS;
         end
         5'b10001: begin
            aluSrc = wiscPkg::SRC_IMM5;
            memRead = 1'b1;
            regWrite = 1'b1;
            regSrc = wiscPkg::WB_MEM;
         end
         // slbi
         5'b10010: begin
            aluSrc = wiscPkg::SRC_IMM8;
            zeroExt = 1'b1;
            aluOp = wiscPkg::ALU_OR;
            regWrite = 1'b1;
            regDest = wiscPkg::DEST_RS;
         end
         // shift and rotate by immediate, opcode low bits pick the operation
         5'b10100, 5'b10101, 5'b10110, 5'b10111: begin
            aluSrc = wiscPkg::SRC_IMM5;
            zeroExt = 1'b1;
            regWrite = 1'b1;
            aluOp = wiscPkg::aluOpT'({1'b0, opcode[1:0]});
         end
         5'b11000: begin
            lbi = 1'b1;
            regWrite = 1'b1;
            regDest = wiscPkg::DEST_RS;
            regSrc = wiscPkg::WB_IMM;
         end
         5'b11001: begin
            btr = 1'b1;
            regWrite = 1'b1;
            regDest = wiscPkg::DEST_RD_LO;
         end
         // r-type shifts and rotates
         5'b11010: begin
            regWrite = 1'b1;
            regDest = wiscPkg::DEST_RD_LO;
            aluOp = wiscPkg::aluOpT'({1'b0, funct});
         end
         // r-type add, sub (rt - rs), xor, andn
         5'b11011: begin
            regWrite = 1'b1;
            regDest = wiscPkg::DEST_RD_LO;
            invA = (funct == 2'b01);
            cin = (funct == 2'b01);
            case (funct)
               2'b10: aluOp = wiscPkg::ALU_XOR;
               2'b11: aluOp = wiscPkg::ALU_ANDN;
               default: aluOp = wiscPkg::ALU_ADD;
            endcase
         end
         // seq, slt, sle subtract, sco only needs the carry of the add
         5'b11100, 5'b11101, 5'b11110, 5'b11111: begin
            setIf = 1'b1;
            regWrite = 1'b1;
            regDest = wiscPkg::DEST_RD_LO;
            setControl = wiscPkg::setControlT'(opcode[1:0]);
            invB = (opcode[1:0] != 2'b11);
            cin = (opcode[1:0] != 2'b11);
         end
         default: ;
      endcase

      // an empty slot must not write, access memory, redirect or stop
      if (!valid) begin
         regWrite = 1'b0;
         memWrite = 1'b0;
         memRead = 1'b0;
         jump = 1'b0;
         aluJump = 1'b0;
         halt = 1'b0;
      end
   end

   assign memAccess = memRead | memWrite;

endmodule

`default_nettype wire

// File: verilog/decode.sv
/*
   Decode stage top: squashes flushed or misaligned instructions, decodes and reads operands
*/
`timescale 1ns/100ps
`default_nettype none

`include "wisc_macros.svh"

module decode (
   input wire clk,
   input wire rst,
   input wire stall,
   input wire wiscPkg::wordT instr,
   input wire valid,
   input wire wiscPkg::wordT writeData,
   input wire mwRegWrite,
   input wire wiscPkg::regIdxT mwWriteReg,
   input wire alignErr,
   input wire flush,
   input wire flushAgain,
   input wire flushFinal,
   input wire mwAlignErr,
   output wire wiscPkg::regSrcT regSrc,
   output wire wiscPkg::regDestT regDest,
   output wire regWrite,
   output wire memWrite,
   output wire memRead,
   output wire memAccess,
   output wire aluJump,
   output wire jump,
   output wire immSrc,
   output wire wiscPkg::brControlT brControl,
   output wire wiscPkg::setControlT setControl,
   output wire wiscPkg::aluOpT aluOp,
   output wire invA,
   output wire invB,
   output wire cin,
   output wire stu,
   output wire btr,
   output wire lbi,
   output wire setIf,
   output wire halt,
   output wire wiscPkg::wordT aluA,
   output wire wiscPkg::wordT aluB,
   output wire wiscPkg::wordT read2Data,
   output wire wiscPkg::wordT imm8Ext,
   output wire wiscPkg::wordT imm11Ext,
   output wire wiscPkg::regIdxT writeReg
);

   wiscPkg::wordT squashedInstr;
   wiscPkg::opcodeT opcode;
   wiscPkg::aluSrcT aluSrc;
   logic zeroExt;
   logic regWriteEn;

   // any mispredict flush turns this slot into a nop
   assign squashedInstr = (flush | flushAgain | flushFinal) ? `NOP_INSTR : instr;
   // fetch alignment fault halts the machine when it retires
   assign opcode = alignErr ? `HALT_OPCODE : squashedInstr[15:11];

   // writeback is held off during a stall or a faulting memory access
   assign regWriteEn = mwRegWrite & ~stall & ~mwAlignErr;

   control ctrl (
      .opcode(opcode), .funct(squashedInstr[1:0]), .valid(valid),
      .aluSrc(aluSrc), .zeroExt(zeroExt), .regSrc(regSrc), .regDest(regDest),
      .regWrite(regWrite), .memWrite(memWrite), .memRead(memRead), .memAccess(memAccess),
      .aluJump(aluJump), .jump(jump), .immSrc(immSrc), .brControl(brControl),
      .setControl(setControl), .aluOp(aluOp), .invA(invA), .invB(invB), .cin(cin),
      .stu(stu), .btr(btr), .lbi(lbi), .setIf(setIf), .halt(halt)
   );

   regFileBypass regFile (
      .clk(clk), .rst(rst),
      .read1Sel(squashedInstr[10:8]), .read2Sel(squashedInstr[7:5]),
      .writeSel(mwWriteReg), .writeData(writeData), .writeEn(regWriteEn),
      .read1Data(aluA), .read2Data(read2Data)
   );

   operandSelect opSel (
      .instr(squashedInstr), .read2Data(read2Data), .aluSrc(aluSrc),
      .regDest(regDest), .zeroExt(zeroExt), .aluB(aluB), .imm5Ext(),
      .imm8Ext(imm8Ext), .imm11Ext(imm11Ext), .writeReg(writeReg)
   );

endmodule

`default_nettype wire

// File: verilog/operandSelect.sv
/*
   Immediate extension plus the ALU B operand and destination register selects
*/
`timescale 1ns/100ps
`default_nettype none

`include "wisc_macros.svh"

module operandSelect (
   input wire wiscPkg::wordT instr,
   input wire wiscPkg::wordT read2Data,
   input wire wiscPkg::aluSrcT aluSrc,
   input wire wiscPkg::regDestT regDest,
   input wire zeroExt,
   output wiscPkg::wordT aluB,
   output wire wiscPkg::wordT imm5Ext,
   output wire wiscPkg::wordT imm8Ext,
   output wire wiscPkg::wordT imm11Ext,
   output wiscPkg::regIdxT writeReg
);

   wire imm5Fill = ~zeroExt & instr[4];
   wire imm8Fill = ~zeroExt & instr[7];

   assign imm5Ext = {{(`WORD_WIDTH-5){imm5Fill}}, instr[4:0]};
   assign imm8Ext = {{(`WORD_WIDTH-8){imm8Fill}}, instr[7:0]};
   // displacement of j and jal is always signed
   assign imm11Ext = {{(`WORD_WIDTH-11){instr[10]}}, instr[10:0]};

   always_comb begin
      case (aluSrc)
         wiscPkg::SRC_IMM8: aluB = imm8Ext;
         wiscPkg::SRC_IMM5: aluB = imm5Ext;
         wiscPkg::SRC_ZERO: aluB = '0;
         default: aluB = read2Data;
      endcase
   end

   always_comb begin
      case (regDest)
         wiscPkg::DEST_RS: writeReg = instr[10:8];
         wiscPkg::DEST_RD_LO: writeReg = instr[4:2];
         wiscPkg::DEST_LINK: writeReg = `LINK_REG;
         default: writeReg = instr[7:5];
      endcase
   end

endmodule

`default_nettype wire

// File: verilog/regFileBypass.sv
/*
   Eight-entry register file with two read ports, one write port and write-through bypass
*/
`timescale 1ns/100ps
`default_nettype none

`include "wisc_macros.svh"

module regFileBypass (
   input wire clk,
   input wire rst,
   input wire wiscPkg::regIdxT read1Sel,
   input wire wiscPkg::regIdxT read2Sel,
   input wire wiscPkg::regIdxT writeSel,
   input wire wiscPkg::wordT writeData,
   input wire writeEn,
   output wire wiscPkg::wordT read1Data,
   output wire wiscPkg::wordT read2Data
);

   wiscPkg::wordT regs [`REG_COUNT];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < `REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (writeEn) begin
         regs[writeSel] <= writeData;
      end
   end

   // a read of the register being written sees the new value this cycle
   assign read1Data = (writeEn && (writeSel == read1Sel)) ? writeData : regs[read1Sel];
   assign read2Data = (writeEn && (writeSel == read2Sel)) ? writeData : regs[read2Sel];

endmodule

`default_nettype wire

// File: verilog/wiscPkg.sv
/*
   Shared ISA types for the decode stage: words, register indices and control fields
*/
`default_nettype none

`include "wisc_macros.svh"

package wiscPkg;

   typedef logic [`WORD_WIDTH-1:0] wordT;
   typedef logic [$clog2(`REG_COUNT)-1:0] regIdxT;
   typedef logic [4:0] opcodeT;

   // low half is shifts and rotates, high half is arithmetic and logic
   typedef enum logic [2:0] {
      ALU_ROL  = 3'b000,
      ALU_SLL  = 3'b001,
      ALU_ROR  = 3'b010,
      ALU_SRL  = 3'b011,
      ALU_ADD  = 3'b100,
      ALU_OR   = 3'b101,
      ALU_XOR  = 3'b110,
      ALU_ANDN = 3'b111
   } aluOpT;

   typedef enum logic [1:0] {
      DEST_RD_HI = 2'b00,
      DEST_RS    = 2'b01,
      DEST_RD_LO = 2'b10,
      DEST_LINK  = 2'b11
   } regDestT;

   typedef enum logic [1:0] {
      SRC_REG  = 2'b00,
      SRC_IMM8 = 2'b01,
      SRC_IMM5 = 2'b10,
      SRC_ZERO = 2'b11
   } aluSrcT;

   typedef enum logic [1:0] {
      WB_ALU = 2'b00,
      WB_MEM = 2'b01,
      WB_PC2 = 2'b10,
      WB_IMM = 2'b11
   } regSrcT;

   // msb set marks a conditional branch, low bits follow the opcode
   typedef enum logic [2:0] {
      BR_NONE = 3'b000,
      BR_EQZ  = 3'b100,
      BR_NEZ  = 3'b101,
      BR_LTZ  = 3'b110,
      BR_GEZ  = 3'b111
   } brControlT;

   typedef enum logic [1:0] {
      SET_EQ    = 2'b00,
      SET_LT    = 2'b01,
      SET_LE    = 2'b10,
      SET_CARRY = 2'b11
   } setControlT;

endpackage

`default_nettype wire

// File: verilog/wisc_macros.svh
/*
   ISA-wide constants for the WISC decode stage, included by the package and the RTL
*/
`ifndef WISC_MACROS_SVH
`define WISC_MACROS_SVH

`define WORD_WIDTH 16
`define REG_COUNT 8
// flushed slots become this word, opcode 00001
`define NOP_INSTR 16'h0800
`define HALT_OPCODE 5'b00000
`define LINK_REG 3'd7

`endif
